// ==== src/isa_pkg.sv ====
package isa_pkg;

    // rv32 major opcodes recognised by decode
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // register view of the word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // split immediate view, used for stores and branches
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // one fetched word, read either way
    typedef union packed {
        r_fmt_t r;
        s_fmt_t s;
    } inst_word_u;

    // instruction classes seen by the back end
    typedef enum logic [2:0] {
        KIND_ALU     = 3'd0,
        KIND_ALU_IMM = 3'd1,
        KIND_LOAD    = 3'd2,
        KIND_STORE   = 3'd3,
        KIND_BRANCH  = 3'd4,
        KIND_ILLEGAL = 3'd5
    } inst_kind_e;

endpackage

// ==== src/ctrl_pkg.sv ====
package ctrl_pkg;

    // both sizes stay powers of two, pointers wrap by overflow
    localparam int ROB_SIZE   = 8;
    localparam int IBUF_DEPTH = 8;

    localparam int ROB_IDX_W  = $clog2(ROB_SIZE);
    localparam int IBUF_PTR_W = $clog2(IBUF_DEPTH);
    // counters must hold the full value, not just an index
    localparam int ROB_CNT_W  = $clog2(ROB_SIZE + 1);
    localparam int IBUF_CNT_W = $clog2(IBUF_DEPTH + 1);

    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;
    typedef logic [ROB_CNT_W-1:0]  rob_cnt_t;
    typedef logic [ROB_CNT_W-1:0]  credit_t;
    typedef logic [IBUF_PTR_W-1:0] ibuf_ptr_t;
    typedef logic [IBUF_CNT_W-1:0] ibuf_cnt_t;

    // fetch to instruction buffer
    typedef struct packed {
        logic [31:0]         pc;
        isa_pkg::inst_word_u inst;
    } fetch_entry_t;

    // decode to rob, padded to 96 bits
    typedef struct packed {
        logic [31:0]         pc;
        isa_pkg::inst_kind_e kind;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic                has_rd;
        logic [31:0]         imm;
        logic [12:0]         pad;
    } dec_info_t;

    typedef struct packed {
        dec_info_t dec;
        rob_idx_t  rob_idx;
    } issue_info_t;

    typedef struct packed {
        rob_idx_t    rob_idx;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        has_rd;
        logic        exc;
    } commit_info_t;

endpackage

// ==== src/inst_buffer.sv ====
`timescale 1ns/1ns

module inst_buffer (
    input  logic                   clk,
    input  logic                   i_rst_n,

    // from fetch
    input  logic                   i_enq_vld,
    input  ctrl_pkg::fetch_entry_t i_enq_entry,
    output logic                   o_full,

    // to decode
    output logic                   o_deq_vld,
    output ctrl_pkg::fetch_entry_t o_deq_entry,
    input  logic                   i_deq
);
    import ctrl_pkg::*;

    fetch_entry_t mem [IBUF_DEPTH];
    ibuf_ptr_t    wr_ptr;
    ibuf_ptr_t    rd_ptr;
    ibuf_cnt_t    count;
    logic         do_enq;
    logic         do_deq;

    assign o_full    = (count == ibuf_cnt_t'(IBUF_DEPTH));
    assign o_deq_vld = (count != '0);

    // full blocks enqueue even if a pop happens in the same cycle
    assign do_enq = i_enq_vld && !o_full;
    assign do_deq = i_deq && o_deq_vld;

    // head read is combinational
    assign o_deq_entry = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= i_enq_entry;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // decode must only pop what it has seen as valid
    a_no_deq_empty: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_deq |-> o_deq_vld
    ) else $error("instruction buffer popped while empty");

    a_count_bound: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        count <= ibuf_cnt_t'(IBUF_DEPTH)
    ) else $error("instruction buffer count above depth");

endmodule

// ==== src/decode.sv ====
`timescale 1ns/1ns

module decode (
    input  logic                   clk,
    input  logic                   i_rst_n,

    // from instruction buffer
    input  logic                   i_inst_vld,
    input  ctrl_pkg::fetch_entry_t i_inst,
    output logic                   o_inst_pop,

    // to rob, credit based
    output logic                   o_disp_vld,
    output ctrl_pkg::dec_info_t    o_disp_info,
    input  logic                   i_credit_ret
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    inst_word_u  word;
    inst_kind_e  kind;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    dec_info_t   dec_nxt;
    logic        out_vld;
    credit_t     credits;
    logic        load_out;

    assign word = i_inst.inst;

    // sign extended immediates
    assign imm_i = {{20{word.r.funct7[6]}}, word.r.funct7, word.r.rs2};
    assign imm_s = {{20{word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};
    assign imm_b = {{19{word.s.imm_hi[6]}}, word.s.imm_hi[6], word.s.imm_lo[0],
                    word.s.imm_hi[5:0], word.s.imm_lo[4:1], 1'b0};

    always_comb begin
        kind = KIND_ILLEGAL;
        case (word.r.opcode)
            OPC_OP:     kind = KIND_ALU;
            OPC_OP_IMM: kind = KIND_ALU_IMM;
            OPC_LOAD: begin
                // lb lh lw lbu lhu only
                if (!(word.r.funct3 inside {3'b011, 3'b110, 3'b111})) begin
                    kind = KIND_LOAD;
                end
            end
            OPC_STORE: begin
                if (word.s.funct3 inside {3'b000, 3'b001, 3'b010}) begin
                    kind = KIND_STORE;
                end
            end
            OPC_BRANCH: kind = KIND_BRANCH;
            default:    kind = KIND_ILLEGAL;
        endcase
    end

    // unused fields stay zero
    always_comb begin
        dec_nxt      = '0;
        dec_nxt.pc   = i_inst.pc;
        dec_nxt.kind = kind;
        case (kind)
            KIND_ALU: begin
                dec_nxt.rd     = word.r.rd;
                dec_nxt.rs1    = word.r.rs1;
                dec_nxt.rs2    = word.r.rs2;
                dec_nxt.has_rd = 1'b1;
            end
            KIND_ALU_IMM, KIND_LOAD: begin
                dec_nxt.rd     = word.r.rd;
                dec_nxt.rs1    = word.r.rs1;
                dec_nxt.has_rd = 1'b1;
                dec_nxt.imm    = imm_i;
            end
            KIND_STORE: begin
                dec_nxt.rs1 = word.s.rs1;
                dec_nxt.rs2 = word.s.rs2;
                dec_nxt.imm = imm_s;
            end
            KIND_BRANCH: begin
                dec_nxt.rs1 = word.s.rs1;
                dec_nxt.rs2 = word.s.rs2;
                dec_nxt.imm = imm_b;
            end
            default: ;
        endcase
    end

    // rob never refuses, so a held credit means the entry leaves now
    assign o_disp_vld = out_vld && (credits != '0);
    assign load_out   = !out_vld || o_disp_vld;
    assign o_inst_pop = i_inst_vld && load_out;

    always_ff @(posedge clk) begin
        if (o_inst_pop) begin
            o_disp_info <= dec_nxt;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            out_vld <= 1'b0;
            credits <= credit_t'(ROB_SIZE);
        end else begin
            if (load_out) begin
                out_vld <= i_inst_vld;
            end
            case ({o_disp_vld, i_credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // more returns than dispatches would overrun the rob
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        credits <= credit_t'(ROB_SIZE)
    ) else $error("decode credits above rob size");

endmodule

// ==== src/rob.sv ====
`timescale 1ns/1ns

module rob (
    input  logic                   clk,
    input  logic                   i_rst_n,

    // dispatch from decode
    input  logic                   i_disp_vld,
    input  ctrl_pkg::dec_info_t    i_disp_info,
    output logic                   o_credit_ret,

    // issue to execution units
    output logic                   o_issue_vld,
    output ctrl_pkg::issue_info_t  o_issue_info,

    // completion
    input  logic                   i_wb_vld,
    input  ctrl_pkg::rob_idx_t     i_wb_idx,

    // commit
    output logic                   o_commit_vld,
    output ctrl_pkg::commit_info_t o_commit_info
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    // per entry payload kept until commit
    typedef struct packed {
        logic        exc;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        has_rd;
    } rob_data_t;

    logic [ROB_SIZE-1:0] ent_vld;
    logic [ROB_SIZE-1:0] ent_done;
    rob_data_t           ent_data [ROB_SIZE];
    rob_idx_t            head;
    rob_idx_t            tail;
    rob_cnt_t            count;
    logic                is_illegal;
    logic                do_commit;
    rob_data_t           head_data;

    assign is_illegal = (i_disp_info.kind == KIND_ILLEGAL);
    assign head_data  = ent_data[head];

    // head leaves once its result is back
    assign do_commit    = ent_vld[head] && ent_done[head];
    assign o_commit_vld = do_commit;
    assign o_credit_ret = do_commit;

    always_comb begin
        o_commit_info.rob_idx = head;
        o_commit_info.pc      = head_data.pc;
        o_commit_info.rd      = head_data.rd;
        o_commit_info.has_rd  = head_data.has_rd;
        o_commit_info.exc     = head_data.exc;
    end

    always_ff @(posedge clk) begin
        if (i_disp_vld) begin
            ent_data[tail].exc    <= is_illegal;
            ent_data[tail].pc     <= i_disp_info.pc;
            ent_data[tail].rd     <= i_disp_info.rd;
            ent_data[tail].has_rd <= i_disp_info.has_rd;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ent_vld  <= '0;
            ent_done <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            if (i_wb_vld) begin
                ent_done[i_wb_idx] <= 1'b1;
            end
            if (do_commit) begin
                ent_vld[head] <= 1'b0;
                head          <= head + 1'b1;
            end
            // illegal entries skip execution and go in finished
            if (i_disp_vld) begin
                ent_vld[tail]  <= 1'b1;
                ent_done[tail] <= is_illegal;
                tail           <= tail + 1'b1;
            end
            case ({i_disp_vld, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // issue one cycle after dispatch
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_issue_vld <= 1'b0;
        end else begin
            o_issue_vld <= i_disp_vld && !is_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (i_disp_vld) begin
            o_issue_info.dec     <= i_disp_info;
            o_issue_info.rob_idx <= tail;
        end
    end

    // decode credits must keep dispatch out of a full rob
    a_no_disp_full: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_disp_vld |-> (count != rob_cnt_t'(ROB_SIZE))
    ) else $error("dispatch into a full rob");

    a_wb_live: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_wb_vld |-> (ent_vld[i_wb_idx] && !ent_done[i_wb_idx])
    ) else $error("writeback to an idle or finished rob entry");

endmodule

// ==== src/ctrl_block.sv ====
`timescale 1ns/1ns

// fetch buffer -> decode -> rob
module ctrl_block (
    input  logic                   clk,
    input  logic                   i_rst_n,

    // from fetch
    input  logic                   i_fetch_vld,
    input  ctrl_pkg::fetch_entry_t i_fetch_entry,
    output logic                   o_stall,

    // to execution units
    output logic                   o_issue_vld,
    output ctrl_pkg::issue_info_t  o_issue_info,

    // writeback from execution units
    input  logic                   i_wb_vld,
    input  ctrl_pkg::rob_idx_t     i_wb_idx,

    // commit
    output logic                   o_commit_vld,
    output ctrl_pkg::commit_info_t o_commit_info
);
    import ctrl_pkg::*;

    logic         ibuf_vld;
    fetch_entry_t ibuf_entry;
    logic         ibuf_pop;
    logic         disp_vld;
    dec_info_t    disp_info;
    logic         credit_ret;

    inst_buffer u_inst_buffer (
        .clk         ( clk           ),
        .i_rst_n     ( i_rst_n       ),
        .i_enq_vld   ( i_fetch_vld   ),
        .i_enq_entry ( i_fetch_entry ),
        .o_full      ( o_stall       ),
        .o_deq_vld   ( ibuf_vld      ),
        .o_deq_entry ( ibuf_entry    ),
        .i_deq       ( ibuf_pop      )
    );

    decode u_decode (
        .clk          ( clk        ),
        .i_rst_n      ( i_rst_n    ),
        .i_inst_vld   ( ibuf_vld   ),
        .i_inst       ( ibuf_entry ),
        .o_inst_pop   ( ibuf_pop   ),
        .o_disp_vld   ( disp_vld   ),
        .o_disp_info  ( disp_info  ),
        .i_credit_ret ( credit_ret )
    );

    rob u_rob (
        .clk           ( clk           ),
        .i_rst_n       ( i_rst_n       ),
        .i_disp_vld    ( disp_vld      ),
        .i_disp_info   ( disp_info     ),
        .o_credit_ret  ( credit_ret    ),
        .o_issue_vld   ( o_issue_vld   ),
        .o_issue_info  ( o_issue_info  ),
        .i_wb_vld      ( i_wb_vld      ),
        .i_wb_idx      ( i_wb_idx      ),
        .o_commit_vld  ( o_commit_vld  ),
        .o_commit_info ( o_commit_info )
    );

endmodule

// ==== testbench/tb_ctrl_block.sv ====
`timescale 1ns/1ns

module tb_ctrl_block;
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int CLK_PERIOD = 4;
    // instructions sent over all tests
    localparam int N_INSTR = 40;

    logic         clk;
    logic         i_rst_n;
    logic         i_fetch_vld;
    fetch_entry_t i_fetch_entry;
    logic         o_stall;
    logic         o_issue_vld;
    issue_info_t  o_issue_info;
    logic         i_wb_vld;
    rob_idx_t     i_wb_idx;
    logic         o_commit_vld;
    commit_info_t o_commit_info;

    fetch_entry_t fetch_q[$];
    issue_info_t  exp_issue_q[$];
    issue_info_t  issue_q[$];
    commit_info_t exp_commit_q[$];
    commit_info_t commit_q[$];
    rob_idx_t     wb_pend[$];
    rob_idx_t     next_idx;
    logic         wb_en;
    logic         wb_random;
    logic         stall_seen;
    logic         feed_done;
    integer       seed;
    int           pick;

    ctrl_block dut0 (
        .clk           ( clk           ),
        .i_rst_n       ( i_rst_n       ),
        .i_fetch_vld   ( i_fetch_vld   ),
        .i_fetch_entry ( i_fetch_entry ),
        .o_stall       ( o_stall       ),
        .o_issue_vld   ( o_issue_vld   ),
        .o_issue_info  ( o_issue_info  ),
        .i_wb_vld      ( i_wb_vld      ),
        .i_wb_idx      ( i_wb_idx      ),
        .o_commit_vld  ( o_commit_vld  ),
        .o_commit_info ( o_commit_info )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // sample outputs and drive writebacks on the falling edge
    always @(negedge clk) begin
        if (i_rst_n) begin
            if (o_issue_vld) begin
                issue_q.push_back(o_issue_info);
                wb_pend.push_back(o_issue_info.rob_idx);
            end
            if (o_commit_vld) begin
                commit_q.push_back(o_commit_info);
            end
            if (o_stall) begin
                stall_seen = 1'b1;
            end
        end
        i_wb_vld = 1'b0;
        if (wb_en && wb_pend.size() > 0) begin
            pick = wb_random ? int'($unsigned($random(seed)) % wb_pend.size()) : 0;
            i_wb_idx = wb_pend[pick];
            wb_pend.delete(pick);
            i_wb_vld = 1'b1;
        end
    end

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            stop_fail($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // rv32 word from its upper 12 bits, rs1, funct3, low 5 bits and opcode
    function automatic logic [31:0] enc(input logic [11:0] hi, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] lo,
                                        input logic [6:0] op);
        return {hi, rs1, f3, lo, op};
    endfunction

    // expected results follow from kind and the fields the test chose
    task automatic queue_inst(input logic [31:0] pc, input logic [31:0] word,
                              input inst_kind_e kind, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [31:0] imm);
        issue_info_t  ei;
        commit_info_t ec;
        ei = '0;
        ei.dec.pc = pc;
        ei.dec.kind = kind;
        ei.dec.rd = rd;
        ei.dec.rs1 = rs1;
        ei.dec.rs2 = rs2;
        ei.dec.imm = imm;
        ei.dec.has_rd = (kind == KIND_ALU || kind == KIND_ALU_IMM || kind == KIND_LOAD);
        ei.rob_idx = next_idx;
        ec = '{rob_idx: next_idx, pc: pc, rd: rd, has_rd: ei.dec.has_rd,
               exc: (kind == KIND_ILLEGAL)};
        fetch_q.push_back({pc, word});
        if (kind != KIND_ILLEGAL) begin
            exp_issue_q.push_back(ei);
        end
        exp_commit_q.push_back(ec);
        next_idx = next_idx + 1'b1;
    endtask

    task automatic feed_all();
        logic taken;
        while (fetch_q.size() > 0) begin
            i_fetch_entry = fetch_q.pop_front();
            i_fetch_vld = 1'b1;
            taken = 1'b0;
            // held until a cycle without stall
            while (!taken) begin
                taken = !o_stall;
                @(negedge clk);
            end
        end
        i_fetch_vld = 1'b0;
        feed_done = 1'b1;
    endtask

    task automatic check_results();
        issue_info_t  gi, ei;
        commit_info_t gc, ec;
        while (commit_q.size() < exp_commit_q.size()) @(negedge clk);
        repeat (4) @(negedge clk);
        check("issue count", issue_q.size(), exp_issue_q.size());
        check("commit count", commit_q.size(), exp_commit_q.size());
        while (exp_issue_q.size() > 0) begin
            gi = issue_q.pop_front();
            ei = exp_issue_q.pop_front();
            check("o_issue_info.rob_idx", gi.rob_idx, ei.rob_idx);
            check("o_issue_info.dec.pc", gi.dec.pc, ei.dec.pc);
            check("o_issue_info.dec.kind", gi.dec.kind, ei.dec.kind);
            check("o_issue_info.dec.rd", gi.dec.rd, ei.dec.rd);
            check("o_issue_info.dec.rs1", gi.dec.rs1, ei.dec.rs1);
            check("o_issue_info.dec.rs2", gi.dec.rs2, ei.dec.rs2);
            check("o_issue_info.dec.has_rd", gi.dec.has_rd, ei.dec.has_rd);
            check("o_issue_info.dec.imm", gi.dec.imm, ei.dec.imm);
        end
        while (exp_commit_q.size() > 0) begin
            gc = commit_q.pop_front();
            ec = exp_commit_q.pop_front();
            check("o_commit_info.rob_idx", gc.rob_idx, ec.rob_idx);
            check("o_commit_info.pc", gc.pc, ec.pc);
            check("o_commit_info.rd", gc.rd, ec.rd);
            check("o_commit_info.has_rd", gc.has_rd, ec.has_rd);
            check("o_commit_info.exc", gc.exc, ec.exc);
        end
    endtask

    task automatic test_reset_state();
        check("o_stall", o_stall, 0);
        check("o_issue_vld", o_issue_vld, 0);
        check("o_commit_vld", o_commit_vld, 0);
        wb_en = 1'b1;
        // first allocation must get index 0
        queue_inst(32'h100, enc({7'h00, 5'd3}, 5'd2, 3'd0, 5'd1, OPC_OP), KIND_ALU, 1, 2, 3, 0);
        feed_all();
        check_results();
    endtask

    task automatic test_decode_fields();
        wb_en = 1'b1;
        queue_inst(32'h200, enc({7'h20, 5'd7}, 5'd6, 3'd0, 5'd5, OPC_OP), KIND_ALU, 5, 6, 7, 0);
        queue_inst(32'h204, enc(12'hffb, 5'd9, 3'd0, 5'd8, OPC_OP_IMM), KIND_ALU_IMM,
                   8, 9, 0, 32'hffff_fffb);
        queue_inst(32'h208, enc(12'h7ff, 5'd21, 3'd0, 5'd20, OPC_OP_IMM), KIND_ALU_IMM,
                   20, 21, 0, 32'h0000_07ff);
        queue_inst(32'h20c, enc(12'h800, 5'd11, 3'd2, 5'd10, OPC_LOAD), KIND_LOAD,
                   10, 11, 0, 32'hffff_f800);
        // sw x14, -12(x15)
        queue_inst(32'h210, enc({7'h7f, 5'd14}, 5'd15, 3'd2, 5'h14, OPC_STORE), KIND_STORE,
                   0, 15, 14, 32'hffff_fff4);
        // beq -4096 and bne +4094 exercise every b-form bit
        queue_inst(32'h214, enc({7'h40, 5'd17}, 5'd16, 3'd0, 5'h00, OPC_BRANCH), KIND_BRANCH,
                   0, 16, 17, 32'hffff_f000);
        queue_inst(32'h218, enc({7'h3f, 5'd19}, 5'd18, 3'd1, 5'h1f, OPC_BRANCH), KIND_BRANCH,
                   0, 18, 19, 32'h0000_0ffe);
        feed_all();
        check_results();
    endtask

    task automatic test_illegal();
        queue_inst(32'h280, enc({7'h00, 5'd2}, 5'd1, 3'd0, 5'd4, OPC_OP), KIND_ALU, 4, 1, 2, 0);
        queue_inst(32'h284, enc({7'h00, 5'd2}, 5'd1, 3'd0, 5'd4, 7'h0b), KIND_ILLEGAL, 0, 0, 0, 0);
        queue_inst(32'h288, enc({7'h00, 5'd3}, 5'd1, 3'd7, 5'd6, OPC_OP), KIND_ALU, 6, 1, 3, 0);
        queue_inst(32'h28c, enc(12'h010, 5'd1, 3'd7, 5'd9, OPC_LOAD), KIND_ILLEGAL, 0, 0, 0, 0);
        feed_all();
        check_results();
    endtask

    task automatic test_in_order();
        wb_en = 1'b0;
        wb_random = 1'b1;
        for (int i = 0; i < 8; i++) begin
            queue_inst(32'h300 + 32'(4 * i), enc(12'(i - 4), 5'(i), 3'd0, 5'(i + 1), OPC_OP_IMM),
                       KIND_ALU_IMM, 5'(i + 1), 5'(i), 0, 32'(i - 4));
        end
        feed_all();
        while (issue_q.size() < 8) @(negedge clk);
        check("commit count before writeback", commit_q.size(), 0);
        wb_en = 1'b1;
        check_results();
        wb_random = 1'b0;
    endtask

    task automatic test_back_pressure();
        wb_en = 1'b0;
        stall_seen = 1'b0;
        feed_done = 1'b0;
        for (int i = 0; i < 20; i++) begin
            queue_inst(32'h400 + 32'(4 * i), enc({7'h00, 5'(i)}, 5'd1, 3'd0, 5'(i + 1), OPC_OP),
                       KIND_ALU, 5'(i + 1), 1, 5'(i), 0);
        end
        fork
            feed_all();
        join_none
        while (!stall_seen) @(negedge clk);
        repeat (8) @(negedge clk);
        check("issues within rob size", issue_q.size() <= ROB_SIZE, 1);
        check("commit count while stalled", commit_q.size(), 0);
        wb_en = 1'b1;
        while (!feed_done) @(negedge clk);
        check_results();
    endtask

    initial begin
        seed = 32'hccb47560;
        i_rst_n = 1'b0;
        i_fetch_vld = 1'b0;
        i_fetch_entry = '0;
        i_wb_vld = 1'b0;
        i_wb_idx = '0;
        next_idx = '0;
        wb_en = 1'b0;
        wb_random = 1'b0;
        stall_seen = 1'b0;
        feed_done = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        test_reset_state();
        test_decode_fields();
        test_illegal();
        test_in_order();
        test_back_pressure();
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // generous budget per instruction
    initial begin
        repeat (40 * N_INSTR) @(posedge clk);
        stop_fail("ERROR: timeout, the DUT stopped committing instructions");
    end

endmodule

// ==== verilog.f ====
src/isa_pkg.sv
src/ctrl_pkg.sv
src/inst_buffer.sv
src/decode.sv
src/rob.sv
src/ctrl_block.sv
testbench/tb_ctrl_block.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator and run, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_ctrl_block -o tb_ctrl_block &&
./obj_dir/tb_ctrl_block || exit 1
